// File: hw/ex_consts.svh
// Execute stage constants: datapath widths, opcode widths and multiplier step counts

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// Data word width
`define EX_XLEN 32

// Register file address width, covers the extended register space
`define EX_REG_ADDR_W 6

//////////////////////////////////////////////////
// Opcodes
//////////////////////////////////////////////////

// ALU operation field
`define EX_ALU_OP_W 4

// Multiplier operation field, MUL or MULHU
`define EX_MULT_OP_W 1

//////////////////////////////////////////////////
// Iterative multiplier
//////////////////////////////////////////////////

// Radix-4, two multiplier bits retired per cycle
`define EX_MULT_STEP_BITS 2

// Busy cycles of one MULHU
`define EX_MULT_STEPS 16

`endif

// File: hw/ex_pkg.sv
// Execute stage package with data word, register address and opcode types

`include "ex_consts.svh"

package ex_pkg;

  // One data word
  typedef logic [`EX_XLEN-1:0] word_t;

  // Register file address
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // ALU operations
  // Arithmetic, logic and shifts first, then set-less-than, then the branch compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MULT_MUL,
    MULT_MULHU
  } mult_op_e;

endpackage

// File: hw/ex_alu.sv
// Integer ALU: add, subtract, logic, shifts, set-less-than and branch compares

`timescale 1ns/100ps

`include "ex_consts.svh"

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  // Signed compares go through the unsigned subtractor with flipped sign bits
  logic                 cmp_signed;
  word_t                sub_a;
  word_t                sub_b;
  logic [`EX_XLEN:0]    sub_full;
  logic                 is_equal;
  logic                 is_less;
  logic [SHAMT_W-1:0]   shamt;
  word_t                add_result;

  //////////////////////////////////////////////////
  // Shared subtractor
  //////////////////////////////////////////////////

  always_comb begin
    cmp_signed = 1'b0;
    case (operator_i)
      ALU_SLT, ALU_LT, ALU_GE: cmp_signed = 1'b1;
      default:                 cmp_signed = 1'b0;
    endcase
  end

  // Flipping both MSBs leaves the low word of the difference unchanged
  assign sub_a = {operand_a_i[`EX_XLEN-1] ^ cmp_signed, operand_a_i[`EX_XLEN-2:0]};
  assign sub_b = {operand_b_i[`EX_XLEN-1] ^ cmp_signed, operand_b_i[`EX_XLEN-2:0]};

  // Top bit is the borrow, set when a < b
  assign sub_full = {1'b0, sub_a} - {1'b0, sub_b};

  assign is_equal = (sub_full[`EX_XLEN-1:0] == '0);
  assign is_less  = sub_full[`EX_XLEN];

  assign add_result = operand_a_i + operand_b_i;
  assign shamt      = operand_b_i[SHAMT_W-1:0];

  //////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_EQ:                           cmp_result_o = is_equal;
      ALU_NE:                           cmp_result_o = ~is_equal;
      ALU_SLT, ALU_SLTU, ALU_LT, ALU_LTU: cmp_result_o = is_less;
      ALU_GE, ALU_GEU:                  cmp_result_o = ~is_less;
      default:                          cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = add_result;
      ALU_SUB: result_o = sub_full[`EX_XLEN-1:0];
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA: result_o = word_t'($signed(operand_a_i) >>> shamt);
      // SLT, SLTU and branch compares return the zero-extended bit
      default: result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: hw/ex_mult.sv
// Multiplier: combinational low product and iterative radix-4 unsigned high product

`timescale 1ns/100ps

`include "ex_consts.svh"

module ex_mult
  import ex_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     enable_i,
  input  mult_op_e operator_i,
  input  word_t    op_a_i,
  input  word_t    op_b_i,
  input  logic     ex_ready_i,
  output word_t    result_o,
  output logic     multicycle_o,
  output logic     ready_o
);

  localparam int CNT_W  = $clog2(`EX_MULT_STEPS);
  localparam int SB     = `EX_MULT_STEP_BITS;
  localparam int PP_W   = `EX_XLEN + SB;
  localparam int ACC_W  = 2 * `EX_XLEN;

  // Control state
  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;

  // Datapath state
  logic [ACC_W-1:0] acc_q;
  word_t            mcand_q;
  word_t            mplier_q;

  logic             start;
  logic             last_step;
  word_t            mcand_src;
  word_t            mplier_src;
  logic [ACC_W-1:0] acc_src;
  logic [SB-1:0]    digit;
  logic [PP_W-1:0]  partial;
  logic [PP_W-1:0]  acc_sum;
  word_t            prod_lo;

  // MUL is a single combinational product
  assign prod_lo = op_a_i * op_b_i;

  // New MULHU only from idle and not on a request already served
  assign start     = enable_i & (operator_i == MULT_MULHU) & ~busy_q & ~done_q;
  assign last_step = (cnt_q == CNT_W'(`EX_MULT_STEPS - 1));

  //////////////////////////////////////////////////
  // Radix-4 shift-add step
  //////////////////////////////////////////////////

  // First step works straight from the ports
  assign mcand_src  = start ? op_a_i : mcand_q;
  assign mplier_src = start ? op_b_i : mplier_q;
  assign acc_src    = start ? '0 : acc_q;

  assign digit   = mplier_src[SB-1:0];
  assign partial = {{SB{1'b0}}, mcand_src} * digit;

  // Upper half plus partial product, whole accumulator then moves right by SB
  assign acc_sum = {{SB{1'b0}}, acc_src[ACC_W-1:`EX_XLEN]} + partial;

  always_ff @(posedge clk) begin
    if (start || busy_q) begin
      acc_q    <= {acc_sum, acc_src[`EX_XLEN-1:SB]};
      mcand_q  <= mcand_src;
      mplier_q <= mplier_src >> SB;
    end
  end

  //////////////////////////////////////////////////
  // Step counter and done flag
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start) begin
      // Step 0 is done in the start cycle
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(1);
    end else if (busy_q) begin
      cnt_q <= cnt_q + CNT_W'(1);
      if (last_step) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (done_q && (!enable_i || ex_ready_i)) begin
      // Request dropped or accepted, back to idle
      done_q <= 1'b0;
    end
  end

  // Busy from the start cycle on, for EX_MULT_STEPS cycles
  assign multicycle_o = start | busy_q;
  assign ready_o      = ~(start | busy_q);

  assign result_o = (operator_i == MULT_MULHU) ? acc_q[ACC_W-1:`EX_XLEN] : prod_lo;

endmodule

// File: hw/ex_result_ctrl.sv
// Result control: ALU write port forward mux and ex_ready / ex_valid generation

`timescale 1ns/100ps

`include "ex_consts.svh"

module ex_result_ctrl
  import ex_pkg::*;
(
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      lsu_en_i,
  input  logic      mult_ready_i,
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  input  logic      branch_in_ex_i,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  output word_t     regfile_alu_wdata_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output logic      regfile_alu_we_fw_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  // All units done and WB able to take the result
  logic units_ready;

  //////////////////////////////////////////////////
  // Forward port mux
  //////////////////////////////////////////////////

  // CSR over multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = {`EX_XLEN{1'b0}};
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve in EX, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid looks only forward, independent of ex_ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// File: hw/ex_wb_reg.sv
// EX/WB pipeline register driving the LSU register file write port

`timescale 1ns/100ps

`include "ex_consts.svh"

module ex_wb_reg
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,
  input  logic      regfile_we_i,
  input  logic      lsu_err_i,
  input  reg_addr_t regfile_waddr_i,
  input  word_t     lsu_rdata_i,
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o
);

  // Write survives only without an LSU error
  logic write_take;

  assign write_take = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= {`EX_REG_ADDR_W{1'b0}};
    end else if (ex_valid_i) begin
      // wb_ready is implied by ex_valid
      regfile_we_wb_o <= write_take;
      if (write_take) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB free but nothing new, flush the old write out
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Load data comes straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: hw/ex_stage.sv
// Execute stage top: ALU, multiplier, forward mux, stall control and EX/WB register

`timescale 1ns/100ps

`include "ex_consts.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // ALU from ID
  input  logic      alu_en_i,
  input  alu_op_e   alu_operator_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  word_t     alu_operand_c_i,

  // Multiplier from ID
  input  logic      mult_en_i,
  input  mult_op_e  mult_operator_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,

  // CSR read
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Register file write requests
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,

  // Branch and LSU
  input  logic      branch_in_ex_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,

  // WB back-pressure
  input  logic      wb_ready_i,

  // Forward port to ID
  output word_t     regfile_alu_wdata_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output logic      regfile_alu_we_fw_o,

  // LSU write port
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,

  // To IF
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                alu_cmp_result;
  logic                mult_ready;

  // Branch target comes precomputed from ID on operand C
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////////////////////////
  // Execution units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // ex_ready feeds back so a finished MULHU is released
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  //////////////////////////////////////////////////
  // Result control and EX/WB register
  //////////////////////////////////////////////////

  ex_result_ctrl u_result_ctrl (
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

  ex_wb_reg u_wb_reg (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .lsu_err_i          (lsu_err_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o)
  );

endmodule

// File: tb/ex_stage_checker.sv
// Execute stage checker with concurrent assertions on the DUT ports against testbench expectations

`timescale 1ns/100ps

`include "ex_consts.svh"

module ex_stage_checker
  import ex_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      alu_en_i,
  input logic      mult_en_i,
  input logic      csr_access_i,
  input logic      lsu_en_i,
  input logic      lsu_ready_ex_i,
  input logic      branch_in_ex_i,
  input logic      wb_ready_i,
  input word_t     lsu_rdata_i,
  input word_t     alu_operand_c_i,
  input logic      regfile_alu_we_i,
  input reg_addr_t regfile_alu_waddr_i,
  input word_t     regfile_alu_wdata_fw_o,
  input reg_addr_t regfile_alu_waddr_fw_o,
  input logic      regfile_alu_we_fw_o,
  input logic      regfile_we_wb_o,
  input reg_addr_t regfile_waddr_wb_o,
  input word_t     regfile_wdata_wb_o,
  input word_t     jump_target_o,
  input logic      branch_decision_o,
  input logic      mult_multicycle_o,
  input logic      ex_ready_o,
  input logic      ex_valid_o
);

  int err_count = 0;

  // Expected values from the testbench
  logic      chk_fw;
  word_t     exp_fw;
  logic      chk_br;
  logic      exp_br;
  logic      chk_wb;
  logic      exp_we;
  reg_addr_t exp_waddr;
  logic      chk_len;
  int        mulhu_len;

  assign chk_fw    = tb_ex_stage.chk_fw;
  assign exp_fw    = tb_ex_stage.exp_fw;
  assign chk_br    = tb_ex_stage.chk_br;
  assign exp_br    = tb_ex_stage.exp_br;
  assign chk_wb    = tb_ex_stage.chk_wb;
  assign exp_we    = tb_ex_stage.exp_we;
  assign exp_waddr = tb_ex_stage.exp_waddr;
  assign chk_len   = tb_ex_stage.chk_len;
  assign mulhu_len = tb_ex_stage.mulhu_len;

  //////////////////////////////////////////////////
  // Forward port and branch
  //////////////////////////////////////////////////

  // Result counts only once EX accepts it
  a_fw_data: assert property (@(posedge clk) disable iff (!rst_n)
    (chk_fw && ex_ready_o) |-> (regfile_alu_wdata_fw_o == exp_fw))
    else begin
      $error("Forward data mismatch");
      err_count++;
    end

  a_fw_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    (regfile_alu_we_fw_o == regfile_alu_we_i) && (regfile_alu_waddr_fw_o == regfile_alu_waddr_i))
    else begin
      $error("Forward address or enable mismatch");
      err_count++;
    end

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    chk_br |-> (branch_decision_o == exp_br) && (jump_target_o == alu_operand_c_i))
    else begin
      $error("Branch decision or target mismatch");
      err_count++;
    end

  a_branch_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex_i |-> ex_ready_o)
    else begin
      $error("Branch stalled");
      err_count++;
    end

  //////////////////////////////////////////////////
  // Multiplier, write port and back-pressure
  //////////////////////////////////////////////////

  a_mult_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_multicycle_o && !branch_in_ex_i) |-> !ex_ready_o)
    else begin
      $error("Ready during MULHU");
      err_count++;
    end

  // A stall with WB and LSU ready can only come from a busy MULHU
  a_mult_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_ready_o && wb_ready_i && lsu_ready_ex_i && !branch_in_ex_i) |-> mult_multicycle_o)
    else begin
      $error("Stall without multicycle flag");
      err_count++;
    end

  a_mulhu_len: assert property (@(posedge clk) disable iff (!rst_n)
    chk_len |-> (mulhu_len == `EX_MULT_STEPS))
    else begin
      $error("MULHU busy length wrong");
      err_count++;
    end

  // Valid needs an enable and a ready stage when no branch is in EX
  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !branch_in_ex_i |->
      (ex_valid_o == ((alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && ex_ready_o)))
    else begin
      $error("Valid does not follow enables and ready");
      err_count++;
    end

  a_wb: assert property (@(posedge clk) disable iff (!rst_n)
    chk_wb |-> (regfile_we_wb_o == exp_we) && (!exp_we || regfile_waddr_wb_o == exp_waddr))
    else begin
      $error("LSU write port mismatch");
      err_count++;
    end

  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_wdata_wb_o == lsu_rdata_i)
    else begin
      $error("LSU write data mismatch");
      err_count++;
    end

  a_bp: assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready_i && !branch_in_ex_i) |-> (!ex_ready_o && !ex_valid_o))
    else begin
      $error("Ready or valid under back-pressure");
      err_count++;
    end

  a_bp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready_i && !branch_in_ex_i) |=>
      ($stable(regfile_we_wb_o) && $stable(regfile_waddr_wb_o)))
    else begin
      $error("Write port moved under back-pressure");
      err_count++;
    end

endmodule

// File: tb/tb_ex_stage.sv
// Execute stage testbench driving directed and random stimulus with expected values for the checker

`timescale 1ns/100ps

`include "ex_consts.svh"

module tb_ex_stage
  import ex_pkg::*;
();

  logic      clk;
  logic      rst_n;
  logic      alu_en_i;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      mult_en_i;
  mult_op_e  mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      branch_in_ex_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  logic      wb_ready_i;
  word_t     regfile_alu_wdata_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  logic      regfile_alu_we_fw_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  word_t     regfile_wdata_wb_o;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      mult_multicycle_o;
  logic      ex_ready_o;
  logic      ex_valid_o;

  // Expected values read by the checker
  logic      chk_fw;
  word_t     exp_fw;
  logic      chk_br;
  logic      exp_br;
  logic      chk_wb;
  logic      exp_we;
  reg_addr_t exp_waddr;
  logic      chk_len;
  int        mulhu_len;

  // Copy of the cycle under check taken at the falling edge
  string     test_name;
  string     snap_name;
  logic      snap_chk_fw;
  logic      snap_chk_br;
  logic      snap_chk_wb;
  logic      snap_chk_len;
  word_t     snap_exp_fw;
  word_t     snap_act_fw;
  logic      snap_exp_br;
  logic      snap_act_br;
  logic      snap_exp_we;
  logic      snap_act_we;
  logic      snap_ready;
  int        snap_len;
  int        seed;

  ex_stage DUT (.*);

  bind ex_stage ex_stage_checker u_checker (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .wb_ready_i             (wb_ready_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .alu_operand_c_i        (alu_operand_c_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .jump_target_o          (jump_target_o),
    .branch_decision_o      (branch_decision_o),
    .mult_multicycle_o      (mult_multicycle_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic cmp_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:          return a == b;
      ALU_NE:          return a != b;
      ALU_SLT, ALU_LT: return $signed(a) < $signed(b);
      ALU_GE:          return $signed(a) >= $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GEU:         return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
      default: return word_t'(cmp_model(op, a, b));
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Cycle handling
  //////////////////////////////////////////////////

  // Report the first failed assertion and stop
  task automatic check_errors();
    if (DUT.u_checker.err_count != 0) begin
      if (snap_chk_fw && snap_act_fw !== snap_exp_fw) begin
        $display("FAIL %s expected %h actual %h", snap_name, snap_exp_fw, snap_act_fw);
      end else if (snap_chk_br && snap_act_br !== snap_exp_br) begin
        $display("FAIL %s expected %b actual %b", snap_name, snap_exp_br, snap_act_br);
      end else if (snap_chk_wb && snap_act_we !== snap_exp_we) begin
        $display("FAIL %s expected %b actual %b", snap_name, snap_exp_we, snap_act_we);
      end else if (snap_chk_len && snap_len != `EX_MULT_STEPS) begin
        $display("FAIL %s expected %0d actual %0d", snap_name, `EX_MULT_STEPS, snap_len);
      end else begin
        $display("A DUT port assertion failed during %s", snap_name);
      end
      $display("Test failed");
      $fatal(1, "Stopped at first error");
    end
  endtask

  // Ends on the rising edge where the caller drives the next inputs
  task automatic cycle();
    @(negedge clk);
    check_errors();
    snap_name    = test_name;
    snap_chk_fw  = chk_fw;
    snap_chk_br  = chk_br;
    snap_chk_wb  = chk_wb;
    snap_chk_len = chk_len;
    snap_exp_fw  = exp_fw;
    snap_act_fw  = regfile_alu_wdata_fw_o;
    snap_exp_br  = exp_br;
    snap_act_br  = branch_decision_o;
    snap_exp_we  = exp_we;
    snap_act_we  = regfile_we_wb_o;
    snap_ready   = ex_ready_o;
    snap_len     = mulhu_len;
    @(posedge clk);
  endtask

  task automatic set_idle();
    alu_en_i       <= 1'b0;
    mult_en_i      <= 1'b0;
    csr_access_i   <= 1'b0;
    lsu_en_i       <= 1'b0;
    branch_in_ex_i <= 1'b0;
    wb_ready_i     <= 1'b1;
    lsu_ready_ex_i <= 1'b1;
    chk_fw         <= 1'b0;
    chk_br         <= 1'b0;
    chk_wb         <= 1'b0;
    chk_len        <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    word_t     a;
    word_t     b;
    logic      we;
    logic      err;
    logic      en;
    reg_addr_t addr;
    logic      model_we;
    reg_addr_t model_addr;
    logic      done;
    int        busy;
    int        tries;
    logic [2:0] combo;
    logic [63:0] prod;

    seed = 64477;
    test_name = "reset";
    rst_n <= 1'b0;
    alu_operator_i <= ALU_ADD;
    alu_operand_a_i <= '0;
    alu_operand_b_i <= '0;
    alu_operand_c_i <= '0;
    mult_operator_i <= MULT_MUL;
    mult_operand_a_i <= '0;
    mult_operand_b_i <= '0;
    csr_rdata_i <= '0;
    regfile_alu_we_i <= 1'b0;
    regfile_alu_waddr_i <= '0;
    regfile_we_i <= 1'b0;
    regfile_waddr_i <= '0;
    lsu_rdata_i <= '0;
    lsu_err_i <= 1'b0;
    exp_fw <= '0;
    exp_br <= 1'b0;
    exp_we <= 1'b0;
    exp_waddr <= '0;
    mulhu_len <= 0;
    set_idle();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Write port cleared by reset
    chk_wb <= 1'b1;
    cycle();

    // EX/WB register with error drop and flush on idle
    test_name  = "wb_reg";
    model_we   = 1'b0;
    model_addr = '0;
    for (int i = 0; i < 60; i++) begin
      en   = (i % 4 != 3);
      we   = 1'($random(seed));
      err  = 1'($random(seed));
      addr = reg_addr_t'($random(seed));
      lsu_en_i        <= en;
      regfile_we_i    <= we;
      lsu_err_i       <= err;
      regfile_waddr_i <= addr;
      lsu_rdata_i     <= $random(seed);
      exp_we          <= model_we;
      exp_waddr       <= model_addr;
      if (en) begin
        model_we = we & ~err;
        if (model_we) begin
          model_addr = addr;
        end
      end else begin
        model_we = 1'b0;
      end
      cycle();
    end

    // Back-pressure holds the write port
    test_name = "backpressure";
    for (int i = 0; i < 30; i++) begin
      wb_ready_i      <= 1'b0;
      lsu_en_i        <= 1'($random(seed));
      alu_en_i        <= 1'($random(seed));
      regfile_we_i    <= 1'($random(seed));
      regfile_waddr_i <= reg_addr_t'($random(seed));
      exp_we          <= model_we;
      exp_waddr       <= model_addr;
      cycle();
    end
    set_idle();
    cycle();

    // Every ALU opcode against the model
    test_name = "alu";
    for (int op = 0; op < 16; op++) begin
      for (int i = 0; i < 40; i++) begin
        a = $random(seed);
        b = (i % 8 == 0) ? a : word_t'($random(seed));
        alu_en_i            <= 1'b1;
        alu_operator_i      <= alu_op_e'(op);
        alu_operand_a_i     <= a;
        alu_operand_b_i     <= b;
        regfile_alu_we_i    <= 1'($random(seed));
        regfile_alu_waddr_i <= reg_addr_t'($random(seed));
        exp_fw              <= alu_model(alu_op_e'(op), a, b);
        chk_fw              <= 1'b1;
        cycle();
      end
    end
    set_idle();

    // Branch decision and target with ready forced under back-pressure
    test_name = "branch";
    for (int i = 0; i < 60; i++) begin
      a = $random(seed);
      b = (i % 3 == 0) ? a : word_t'($random(seed));
      branch_in_ex_i  <= 1'b1;
      wb_ready_i      <= 1'($random(seed));
      alu_operator_i  <= alu_op_e'(10 + i % 6);
      alu_operand_a_i <= a;
      alu_operand_b_i <= b;
      alu_operand_c_i <= $random(seed);
      exp_br          <= cmp_model(alu_op_e'(10 + i % 6), a, b);
      chk_br          <= 1'b1;
      cycle();
    end
    set_idle();

    // Single-cycle low product
    test_name = "mul";
    for (int i = 0; i < 20; i++) begin
      a = $random(seed);
      b = $random(seed);
      mult_en_i        <= 1'b1;
      mult_operator_i  <= MULT_MUL;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      exp_fw           <= a * b;
      chk_fw           <= 1'b1;
      cycle();
    end

    // Multicycle high product with the busy length counted here
    test_name = "mulhu";
    for (int i = 0; i < 4; i++) begin
      a    = (i == 0) ? 32'hffff_ffff : word_t'($random(seed));
      b    = (i == 0) ? 32'hffff_ffff : word_t'($random(seed));
      prod = {32'b0, a} * {32'b0, b};
      mult_en_i        <= 1'b1;
      mult_operator_i  <= MULT_MULHU;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      exp_fw           <= prod[63:32];
      chk_fw           <= 1'b1;
      chk_len          <= 1'b0;
      done  = 1'b0;
      busy  = 0;
      tries = 0;
      while (!done && tries < 100) begin
        cycle();
        tries++;
        if (snap_ready) begin
          done = 1'b1;
        end else begin
          busy++;
        end
      end
      if (!done) begin
        $display("Timeout waiting for ex_ready_o after MULHU");
        $display("Test failed");
        $fatal(1, "Timeout");
      end
      mult_en_i <= 1'b0;
      chk_fw    <= 1'b0;
      chk_len   <= 1'b1;
      mulhu_len <= busy;
      cycle();
    end
    set_idle();

    // CSR over multiplier over ALU
    test_name = "priority";
    for (int i = 0; i < 28; i++) begin
      combo = 3'(i % 7 + 1);
      a = $random(seed);
      b = $random(seed);
      csr_access_i     <= combo[2];
      mult_en_i        <= combo[1];
      alu_en_i         <= combo[0];
      mult_operator_i  <= MULT_MUL;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      alu_operator_i   <= ALU_XOR;
      alu_operand_a_i  <= a;
      alu_operand_b_i  <= b;
      csr_rdata_i      <= ~a;
      exp_fw           <= combo[2] ? ~a : (combo[1] ? a * b : a ^ b);
      chk_fw           <= 1'b1;
      cycle();
    end
    set_idle();
    cycle();
    cycle();

    // Assertions of the last rising edge have reported by the falling edge
    @(negedge clk);
    if (DUT.u_checker.err_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "Errors at end of run");
    end
  end

endmodule

// File: sim.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_result_ctrl.sv
hw/ex_wb_reg.sv
hw/ex_stage.sv
tb/ex_stage_checker.sv
tb/tb_ex_stage.sv

// File: Makefile
# Verilator build and run for the execute stage testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ex_stage
FILELIST  = sim.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code
run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
